// ==== verilog/kd_geom_pkg.sv ====
/*
  KD-tree geometry definitions
  Patch layout, node word layout and the helpers that split a node word
  into its dimension index and signed median
*/

package kd_geom_pkg;

  localparam int COORD_WIDTH     = 11;                       // One signed coordinate
  localparam int DIM_COUNT       = 5;                        // Coordinates per patch
  localparam int PATCH_WIDTH     = DIM_COUNT * COORD_WIDTH;  // 55 bits, dim d at 11*d
  localparam int DIM_SEL_WIDTH   = 3;                        // Stored dimension index
  localparam int NODE_WORD_WIDTH = 2 * COORD_WIDTH;          // Index half + median half

  // Invalid dimension held after reset, slices as coordinate 0
  localparam logic [DIM_SEL_WIDTH-1:0] DIM_RESET = 3'd7;

  // Dimension index sits in the low bits of the lower half
  function automatic logic [DIM_SEL_WIDTH-1:0] node_dim(
    input logic [NODE_WORD_WIDTH-1:0] word
  );
    return word[DIM_SEL_WIDTH-1:0];
  endfunction

  // Median is the whole upper half, kept signed
  function automatic logic signed [COORD_WIDTH-1:0] node_median(
    input logic [NODE_WORD_WIDTH-1:0] word
  );
    return $signed(word[NODE_WORD_WIDTH-1:COORD_WIDTH]);
  endfunction

endpackage

// ==== verilog/kd_ctrl_pkg.sv ====
/*
  KD-tree control encodings
  Host command opcodes and node loader states
*/

package kd_ctrl_pkg;

  // Command channel opcode
  typedef enum logic [1:0] {
    op_nop         = 2'd0,  // Credit still returned
    op_node_write  = 2'd1,  // Write next node, breadth-first
    op_addr_rewind = 2'd2   // Back to node 0, contents kept
  } cmd_op_e;

  // Loader fill state
  typedef enum logic {
    ld_filling = 1'b0,
    ld_full    = 1'b1
  } load_state_e;

endpackage

// ==== verilog/kd_node_loader.sv ====
/*
  Node loader
  Decodes host commands into breadth-first node writes
  and echoes one command credit per accepted command
*/

module kd_node_loader #(
  parameter int KD_DEPTH = 6
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   cmd_valid,
  input  kd_ctrl_pkg::cmd_op_e                   cmd_op,
  input  logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] cmd_data,
  output logic                                   cmd_credit,
  output logic                                   node_wen,
  output logic [KD_DEPTH-1:0]                    node_waddr,
  output logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] node_wdata,
  output logic                                   tree_loaded
);

  // Address of the last internal node, 2^KD_DEPTH - 2
  localparam logic [KD_DEPTH-1:0] LAST_ADDR = KD_DEPTH'((2 ** KD_DEPTH) - 2);

  kd_ctrl_pkg::load_state_e state;
  logic [KD_DEPTH-1:0]      wr_ptr;  // Next node to write

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= kd_ctrl_pkg::ld_filling;
      wr_ptr     <= '0;
      node_wen   <= 1'b0;
      cmd_credit <= 1'b0;
    end else begin
      node_wen   <= 1'b0;
      cmd_credit <= cmd_valid;  // Nothing is refused
      if (cmd_valid) begin
        case (cmd_op)
          kd_ctrl_pkg::op_node_write: begin
            if (state == kd_ctrl_pkg::ld_filling) begin  // Dropped once full
              node_wen <= 1'b1;
              wr_ptr   <= wr_ptr + 1'b1;
              if (wr_ptr == LAST_ADDR) state <= kd_ctrl_pkg::ld_full;
            end
          end
          kd_ctrl_pkg::op_addr_rewind: begin
            wr_ptr <= '0;
            state  <= kd_ctrl_pkg::ld_filling;
          end
          kd_ctrl_pkg::op_nop: ;
          default: ;  // Unused code, treated as nop
        endcase
      end
    end
  end

  // Write payload, qualified by node_wen
  always_ff @(posedge clk) begin
    node_waddr <= wr_ptr;
    node_wdata <= cmd_data;
  end

  assign tree_loaded = (state == kd_ctrl_pkg::ld_full);

endmodule

// ==== verilog/kd_tree_level.sv ====
/*
  One depth of the KD-tree search pipeline
  Holds the 2^LEVEL nodes of its level, picks the node named by the path so far,
  compares the chosen coordinate with the median and registers the result
*/

module kd_tree_level #(
  parameter int KD_DEPTH = 6,
  parameter int LEVEL    = 0
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   node_wen,
  input  logic [KD_DEPTH-1:0]                    node_waddr,
  input  logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] node_wdata,
  input  logic                                   in_valid,
  input  logic [kd_geom_pkg::PATCH_WIDTH-1:0]     in_patch,
  input  logic [KD_DEPTH-1:0]                    in_path,
  output logic                                   out_valid,
  output logic [kd_geom_pkg::PATCH_WIDTH-1:0]     out_patch,
  output logic [KD_DEPTH-1:0]                    out_path
);

  localparam int NODES     = 1 << LEVEL;
  localparam int BASE      = NODES - 1;                     // First breadth-first address
  localparam int IDX_WIDTH = (LEVEL > 0) ? LEVEL : 1;
  localparam logic [KD_DEPTH-1:0] PATH_MASK = KD_DEPTH'(NODES - 1);  // Path bits so far

  logic [kd_geom_pkg::DIM_SEL_WIDTH-1:0]      dim_mem [NODES];
  logic signed [kd_geom_pkg::COORD_WIDTH-1:0] med_mem [NODES];

  logic [KD_DEPTH-1:0]                        wr_off;
  logic                                       wr_hit;
  logic [IDX_WIDTH-1:0]                       wr_idx;
  logic [IDX_WIDTH-1:0]                       rd_idx;
  logic [kd_geom_pkg::DIM_SEL_WIDTH-1:0]      sel_dim;
  logic signed [kd_geom_pkg::COORD_WIDTH-1:0] sel_med;
  logic signed [kd_geom_pkg::COORD_WIDTH-1:0] coord;
  logic                                       go_right;

  // Address decode for this level only
  assign wr_off = node_waddr - KD_DEPTH'(BASE);  // Lower levels wrap far above NODES
  assign wr_hit = node_wen && (wr_off < KD_DEPTH'(NODES));
  assign wr_idx = IDX_WIDTH'(wr_off);

  // Node storage resets to the invalid dimension so queries go right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NODES; i++) begin
        dim_mem[i] <= kd_geom_pkg::DIM_RESET;
        med_mem[i] <= '0;
      end
    end else if (wr_hit) begin
      dim_mem[wr_idx] <= kd_geom_pkg::node_dim(node_wdata);
      med_mem[wr_idx] <= kd_geom_pkg::node_median(node_wdata);
    end
  end

  assign rd_idx  = IDX_WIDTH'(in_path & PATH_MASK);  // Level 0 always reads node 0
  assign sel_dim = dim_mem[rd_idx];
  assign sel_med = med_mem[rd_idx];

  // Slice the chosen coordinate; dims 5 and up read as 0
  always_comb begin
    coord = '0;
    for (int d = 0; d < kd_geom_pkg::DIM_COUNT; d++) begin
      if (sel_dim == kd_geom_pkg::DIM_SEL_WIDTH'(d)) begin
        coord = in_patch[d*kd_geom_pkg::COORD_WIDTH +: kd_geom_pkg::COORD_WIDTH];
      end
    end
  end

  assign go_right = !(coord < sel_med);  // Signed compare where equal goes right

  always_ff @(posedge clk) begin
    if (!rst_n) out_valid <= 1'b0;
    else        out_valid <= in_valid;
  end

  // Patch and path move on with the valid bit
  always_ff @(posedge clk) begin
    out_patch <= in_patch;
    out_path  <= {in_path[KD_DEPTH-2:0], go_right};  // New bit at LSB so the root ends at MSB
  end

endmodule

// ==== verilog/kd_search_pipeline.sv ====
/*
  KD-tree search pipeline
  Chains KD_DEPTH level blocks, one depth per clock,
  from an empty path down to the full leaf index
*/

module kd_search_pipeline #(
  parameter int KD_DEPTH = 6
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   node_wen,
  input  logic [KD_DEPTH-1:0]                    node_waddr,
  input  logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] node_wdata,
  input  logic                                   query_valid,
  input  logic [kd_geom_pkg::PATCH_WIDTH-1:0]     query_patch,
  output logic                                   leaf_valid,
  output logic [KD_DEPTH-1:0]                    leaf_index
);

  // Stage k feeds level k, stage KD_DEPTH is the leaf
  logic                               stage_valid [KD_DEPTH+1];
  logic [kd_geom_pkg::PATCH_WIDTH-1:0] stage_patch [KD_DEPTH+1];
  logic [KD_DEPTH-1:0]                stage_path  [KD_DEPTH+1];

  assign stage_valid[0] = query_valid;
  assign stage_patch[0] = query_patch;
  assign stage_path[0]  = '0;  // No decisions yet

  for (genvar lvl = 0; lvl < KD_DEPTH; lvl++) begin : g_level
    kd_tree_level #(
      .KD_DEPTH (KD_DEPTH),
      .LEVEL    (lvl)
    ) u_level (
      .clk        (clk),
      .rst_n      (rst_n),
      .node_wen   (node_wen),     // Broadcast, each level decodes its range
      .node_waddr (node_waddr),
      .node_wdata (node_wdata),
      .in_valid   (stage_valid[lvl]),
      .in_patch   (stage_patch[lvl]),
      .in_path    (stage_path[lvl]),
      .out_valid  (stage_valid[lvl+1]),
      .out_patch  (stage_patch[lvl+1]),
      .out_path   (stage_path[lvl+1])
    );
  end

  assign leaf_valid = stage_valid[KD_DEPTH];
  assign leaf_index = stage_path[KD_DEPTH];

endmodule

// ==== verilog/kd_leaf_egress.sv ====
/*
  Leaf egress
  Buffers leaf indices in a small FIFO, sends them under result credits
  and hands a query credit back to the host for each result sent
*/

module kd_leaf_egress #(
  parameter int KD_DEPTH   = 6,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                leaf_valid,
  input  logic [KD_DEPTH-1:0] leaf_index,
  input  logic                res_credit,
  output logic                result_valid,
  output logic [KD_DEPTH-1:0] result_leaf,
  output logic                query_credit
);

  localparam int PTR_WIDTH    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH    = $clog2(FIFO_DEPTH + 1);
  localparam int CREDIT_WIDTH = 8;  // Sink grants at most a handful ahead
  localparam logic [PTR_WIDTH-1:0] PTR_LAST = PTR_WIDTH'(FIFO_DEPTH - 1);

  logic [KD_DEPTH-1:0]     fifo_mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]    wr_ptr;
  logic [PTR_WIDTH-1:0]    rd_ptr;
  logic [CNT_WIDTH-1:0]    count;
  logic [CREDIT_WIDTH-1:0] credits;
  logic                    push;
  logic                    pop;

  assign pop  = (count != '0) && (credits != '0);        // Head out when sink has room
  assign push = leaf_valid && ((count != CNT_WIDTH'(FIFO_DEPTH)) || pop);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credits      <= '0;
      result_valid <= 1'b0;
      query_credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither, level unchanged
      endcase
      // Grant and spend may land in the same cycle
      credits      <= credits + CREDIT_WIDTH'(res_credit) - CREDIT_WIDTH'(pop);
      result_valid <= pop;
      query_credit <= pop;  // Slot freed, host may send one more query
    end
  end

  // Storage and output payload
  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= leaf_index;
    if (pop)  result_leaf <= fifo_mem[rd_ptr];
  end

endmodule

// ==== verilog/kd_search_top.sv ====
/*
  KD-tree patch search engine, top level
  Node loader, search pipeline and leaf egress wired together
*/

module kd_search_top #(
  parameter int KD_DEPTH   = 6,
  parameter int FIFO_DEPTH = 4  // Also the host's starting query credits
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   cmd_valid,
  input  kd_ctrl_pkg::cmd_op_e                   cmd_op,
  input  logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] cmd_data,
  output logic                                   cmd_credit,
  output logic                                   tree_loaded,
  input  logic                                   query_valid,
  input  logic [kd_geom_pkg::PATCH_WIDTH-1:0]     query_patch,
  output logic                                   query_credit,
  input  logic                                   res_credit,
  output logic                                   result_valid,
  output logic [KD_DEPTH-1:0]                    result_leaf
);

  // Node write bus, broadcast to every level
  logic                                   node_wen;
  logic [KD_DEPTH-1:0]                    node_waddr;
  logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] node_wdata;
  // Pipeline to egress
  logic                                   leaf_valid;
  logic [KD_DEPTH-1:0]                    leaf_index;

  kd_node_loader #(.KD_DEPTH(KD_DEPTH)) u_loader (
    .clk(clk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data),
    .cmd_credit(cmd_credit),
    .node_wen(node_wen), .node_waddr(node_waddr), .node_wdata(node_wdata),
    .tree_loaded(tree_loaded)
  );

  kd_search_pipeline #(.KD_DEPTH(KD_DEPTH)) u_pipeline (
    .clk(clk), .rst_n(rst_n),
    .node_wen(node_wen), .node_waddr(node_waddr), .node_wdata(node_wdata),
    .query_valid(query_valid), .query_patch(query_patch),
    .leaf_valid(leaf_valid), .leaf_index(leaf_index)
  );

  kd_leaf_egress #(.KD_DEPTH(KD_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) u_egress (
    .clk(clk), .rst_n(rst_n),
    .leaf_valid(leaf_valid), .leaf_index(leaf_index),
    .res_credit(res_credit),
    .result_valid(result_valid), .result_leaf(result_leaf),
    .query_credit(query_credit)
  );

endmodule

// ==== tb/kd_tree_model.svh ====
/*
  Reference model for the KD-tree search testbench
  Mirrors the breadth-first node arrays, supplies xorshift random numbers
  and predicts the leaf that a query patch reaches
*/
`ifndef KD_TREE_MODEL_SVH
`define KD_TREE_MODEL_SVH

logic [kd_geom_pkg::DIM_SEL_WIDTH-1:0]      m_dim [NODE_COUNT];
logic signed [kd_geom_pkg::COORD_WIDTH-1:0] m_med [NODE_COUNT];
int                                         m_ptr;                // Next node the loader fills
logic [31:0]                                rng_state = 32'hc432;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

function logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// After reset every node is invalid dim 7 with median 0
function void model_reset();
  for (int i = 0; i < NODE_COUNT; i++) begin
    m_dim[i] = 3'd7;
    m_med[i] = '0;
  end
  m_ptr = 0;
endfunction

// Dim in the low 3 bits, signed median in the upper half
function void model_write(input logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] word);
  if (m_ptr < NODE_COUNT) begin  // Writes past a full tree are lost
    m_dim[m_ptr] = word[kd_geom_pkg::DIM_SEL_WIDTH-1:0];
    m_med[m_ptr] = word[kd_geom_pkg::NODE_WORD_WIDTH-1:kd_geom_pkg::COORD_WIDTH];
    m_ptr++;
  end
endfunction

// Walk from the root, left child 2n+1 when coord < median, else 2n+2
function automatic logic [KD_DEPTH-1:0] predict_leaf(
  input logic [kd_geom_pkg::PATCH_WIDTH-1:0] patch
);
  int                                         node;
  logic signed [kd_geom_pkg::COORD_WIDTH-1:0] coord;
  node = 0;
  for (int lvl = 0; lvl < KD_DEPTH; lvl++) begin
    coord = '0;  // Dims 5..7 read as zero
    if (int'(m_dim[node]) < kd_geom_pkg::DIM_COUNT)
      coord = patch[int'(m_dim[node]) * kd_geom_pkg::COORD_WIDTH +: kd_geom_pkg::COORD_WIDTH];
    node = (coord < m_med[node]) ? 2 * node + 1 : 2 * node + 2;
  end
  return KD_DEPTH'(node - NODE_COUNT);  // Leaves start right after the last internal node
endfunction

`endif

// ==== tb/kd_search_tb.sv ====
/*
  Testbench for the KD-tree patch search engine
  Loads nodes over the credited command channel, streams queries
  and checks every leaf against the reference model
*/

module kd_search_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int KD_DEPTH   = 6;
  localparam int FIFO_DEPTH = 4;
  localparam int NODE_COUNT = (1 << KD_DEPTH) - 1;
  // Commands of full_load, invalid_dims and rewind_partial
  localparam int CMD_TOTAL   = NODE_COUNT + (1 + NODE_COUNT + 8) + (1 + NODE_COUNT);
  localparam int QUERY_TOTAL = 16 + 200 + 64 + 64 + 32 + FIFO_DEPTH;
  localparam int DRAIN_CYCLES = 4 * (KD_DEPTH + FIFO_DEPTH + 8);  // Per test
  localparam int CYCLE_LIMIT = 2 * (8 + 2 * CMD_TOTAL + (KD_DEPTH + 4) * QUERY_TOTAL
                                    + 5 * DRAIN_CYCLES);

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  logic                                   cmd_valid;
  kd_ctrl_pkg::cmd_op_e                   cmd_op;
  logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] cmd_data;
  logic                                   cmd_credit;
  logic                                   tree_loaded;
  logic                                   query_valid;
  logic [kd_geom_pkg::PATCH_WIDTH-1:0]     query_patch;
  logic                                   query_credit;
  logic                                   res_credit;
  logic                                   result_valid;
  logic [KD_DEPTH-1:0]                    result_leaf;

  int                  cmd_avail    = 1;           // Host command credits
  int                  q_avail      = FIFO_DEPTH;  // Host query credits
  int                  cmd_pulses   = 0;
  int                  cmds_sent    = 0;
  int                  granted      = 0;           // res_credit pulses given
  int                  results_seen = 0;
  int                  cycle_count  = 0;
  bit                  sink_auto    = 1'b1;        // Sink grants on its own
  logic [KD_DEPTH-1:0] expected [$];               // Leaves in query order

  `include "kd_tree_model.svh"

  kd_search_top #(.KD_DEPTH(KD_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) dut (
    .clk(clk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data),
    .cmd_credit(cmd_credit), .tree_loaded(tree_loaded),
    .query_valid(query_valid), .query_patch(query_patch), .query_credit(query_credit),
    .res_credit(res_credit), .result_valid(result_valid), .result_leaf(result_leaf)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_leaf(input string name, input logic [KD_DEPTH-1:0] actual,
                            input logic [KD_DEPTH-1:0] exp_leaf);
    if (actual !== exp_leaf)
      report_fail($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, exp_leaf));
  endtask

  task automatic check_flag(input string name, input logic actual, input logic exp_flag);
    if (actual !== exp_flag)
      report_fail($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, exp_flag));
  endtask

  task automatic check_count(input string name, input int actual, input int exp_count);
    if (actual != exp_count)
      report_fail($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, exp_count));
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
      report_fail($sformatf("Run timed out after %0d cycles", cycle_count));
  end

  // Outputs sampled mid-cycle, away from the drive point
  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_credit) begin
        cmd_avail++;
        cmd_pulses++;
      end
      if (query_credit) q_avail++;
      if (result_valid) begin
        if (expected.size() == 0) report_fail("result_valid rose with no query outstanding");
        check_leaf("result_leaf", result_leaf, expected.pop_front());
        results_seen++;
      end
    end
  end

  // Sink keeps unused grants below both 2 and the results still due
  always @(posedge clk) begin
    #1;
    if (sink_auto) begin
      if (rst_n && (granted - results_seen < 2) && (granted - results_seen < expected.size())) begin
        res_credit = 1'b1;
        granted++;
      end else begin
        res_credit = 1'b0;
      end
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;  // Drive point
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  function automatic logic [kd_geom_pkg::PATCH_WIDTH-1:0] random_patch();
    logic [kd_geom_pkg::PATCH_WIDTH-1:0] p;
    logic [31:0]                        r;
    for (int d = 0; d < kd_geom_pkg::DIM_COUNT; d++) begin
      r = next_rand();
      p[d*kd_geom_pkg::COORD_WIDTH +: kd_geom_pkg::COORD_WIDTH] = r[10:0];
    end
    return p;
  endfunction

  // Random median and filler bits around a chosen dimension
  function automatic logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] random_node(input logic [2:0] dim);
    logic [31:0] r;
    r = next_rand();
    return {r[26:16], r[10:3], dim};
  endfunction

  task automatic send_cmd(input kd_ctrl_pkg::cmd_op_e op,
                          input logic [kd_geom_pkg::NODE_WORD_WIDTH-1:0] data);
    while (cmd_avail == 0) step_cycle();
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_data  = data;
    cmd_avail--;
    cmds_sent++;
    if (op == kd_ctrl_pkg::op_node_write) model_write(data);
    else if (op == kd_ctrl_pkg::op_addr_rewind) m_ptr = 0;  // Contents stay
    step_cycle();
    cmd_valid = 1'b0;
    cmd_op    = kd_ctrl_pkg::op_nop;
  endtask

  task automatic load_nodes(input int count, input int dim_span);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = next_rand();
      send_cmd(kd_ctrl_pkg::op_node_write, random_node(3'(r % 32'(dim_span))));
    end
  endtask

  task automatic send_query(input logic [kd_geom_pkg::PATCH_WIDTH-1:0] patch);
    while (q_avail == 0) step_cycle();  // Host obeys query credits
    query_valid = 1'b1;
    query_patch = patch;
    q_avail--;
    expected.push_back(predict_leaf(patch));
    step_cycle();
    query_valid = 1'b0;
  endtask

  task automatic run_queries(input int n);
    repeat (n) send_query(random_patch());
  endtask

  task automatic drain_results();
    while (expected.size() != 0) step_cycle();
    wait_cycles(2);
    check_count("query credits", q_avail, FIFO_DEPTH);
  endtask

  task automatic grant_one();
    res_credit = 1'b1;
    granted++;
    step_cycle();
    res_credit = 1'b0;
  endtask

  // Empty tree sends every query right to the last leaf
  task automatic reset_routing();
    check_flag("tree_loaded", tree_loaded, 1'b0);
    run_queries(16);
    drain_results();
  endtask

  task automatic full_load();
    load_nodes(NODE_COUNT, kd_geom_pkg::DIM_COUNT);
    wait_cycles(2);
    check_flag("tree_loaded", tree_loaded, 1'b1);
    check_count("cmd_credit pulses", cmd_pulses, cmds_sent);
    run_queries(200);
    drain_results();
  endtask

  task automatic invalid_dims();
    send_cmd(kd_ctrl_pkg::op_addr_rewind, '0);
    for (int i = 0; i < 3; i++) send_cmd(kd_ctrl_pkg::op_node_write, random_node(3'(5 + i)));
    load_nodes(NODE_COUNT - 3, 8);  // Any dim 0..7
    load_nodes(8, kd_geom_pkg::DIM_COUNT);  // Tree full, these must be dropped
    wait_cycles(2);
    check_flag("tree_loaded", tree_loaded, 1'b1);
    run_queries(64);
    drain_results();
  endtask

  task automatic rewind_partial();
    send_cmd(kd_ctrl_pkg::op_addr_rewind, '0);
    check_flag("tree_loaded", tree_loaded, 1'b0);
    load_nodes(3, kd_geom_pkg::DIM_COUNT);  // Root and its two children only
    wait_cycles(2);
    check_flag("tree_loaded", tree_loaded, 1'b0);
    run_queries(64);
    drain_results();
    load_nodes(NODE_COUNT - 3, kd_geom_pkg::DIM_COUNT);
    wait_cycles(2);
    check_flag("tree_loaded", tree_loaded, 1'b1);
    run_queries(32);
    drain_results();
  endtask

  task automatic back_pressure();
    int base;
    sink_auto  = 1'b0;
    res_credit = 1'b0;
    base       = results_seen;
    run_queries(FIFO_DEPTH);
    wait_cycles(KD_DEPTH + 8);  // Well past pipeline latency
    check_count("result_valid pulses", results_seen, base);
    check_count("query credits", q_avail, 0);
    for (int i = 1; i <= FIFO_DEPTH; i++) begin
      grant_one();
      while (results_seen != base + i) step_cycle();
      wait_cycles(4);
      check_count("result_valid pulses", results_seen, base + i);  // One result per credit
      check_count("query credits", q_avail, i);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_op      = kd_ctrl_pkg::op_nop;
    cmd_data    = '0;
    query_valid = 1'b0;
    query_patch = '0;
    res_credit  = 1'b0;
    model_reset();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step_cycle();
    reset_routing();
    full_load();
    invalid_dims();
    rewind_partial();
    back_pressure();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+tb
verilog/kd_geom_pkg.sv
verilog/kd_ctrl_pkg.sv
verilog/kd_node_loader.sv
verilog/kd_tree_level.sv
verilog/kd_search_pipeline.sv
verilog/kd_leaf_egress.sv
verilog/kd_search_top.sv
tb/kd_search_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the KD-tree search regression with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f list.f --top-module kd_search_tb -o kd_search_sim
./obj_dir/kd_search_sim
